// File: src.f
common/conv_weights_pkg.sv
load_weights/conv_load_weights_controller.sv
load_weights/weights_buf.sv
hw/conv_tile_sequencer.sv
hw/conv_weights_top.sv
tests/conv_weights_sva.sv
tests/ddr_read_model.sv
tests/tb_conv_weights.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_conv_weights \
  -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log
grep -qx '\*\* PASS \*\*' sim.log && exit 0 || exit 1

// File: tests/tb_conv_weights.sv
`timescale 1ns/100ps

module tb_conv_weights
  import conv_weights_pkg::*;
();

  localparam int num_tests     = 4;
  localparam int row_num_mode0 = 64;
  localparam int row_num_mode1 = 128;
  localparam int buf_adr_w     = 10;

  logic                 clk;
  logic                 reset;
  logic                 layer_start;
  layer_cfg_t           layer_cfg;
  logic                 ddr_en;
  ddr_rd_req_t          ddr_rd_req;
  ddr_rd_rsp_t          ddr_rd_rsp;
  logic                 tile_ready;
  logic                 tile_consumed;
  logic                 buf_rd_en;
  logic [buf_adr_w-1:0] buf_rd_adr;
  weights_word_t        buf_rd_data;
  logic                 layer_done;
  int unsigned          tests_passed;
  int unsigned          tests_failed;

  conv_weights_top #(
    .row_num_mode0 (row_num_mode0),
    .row_num_mode1 (row_num_mode1),
    .buf_adr_w     (buf_adr_w)
  ) dut (.*);

  ddr_read_model ddr (.clk, .reset, .ddr_rd_req, .ddr_en, .ddr_rd_rsp);

  bind conv_weights_top conv_weights_sva #(
    .row_num_mode0 (row_num_mode0),
    .row_num_mode1 (row_num_mode1),
    .buf_adr_w     (buf_adr_w)
  ) u_sva (.*);

  ////////////////////////////////////////
  // layer table
  ////////////////////////////////////////

  // layer 1 ends exactly on a tile boundary
  function automatic layer_cfg_t test_cfg(input int idx);
    layer_cfg_t c;
    c = '0;
    case (idx)
      0: c = '{mode: 1'b0, nif_k_k: 32'd12, of: 32'd150, base_adr: 32'h0000_1000};
      1: c = '{mode: 1'b1, nif_k_k: 32'd20, of: 32'd256, base_adr: 32'h0000_2400};
      2: c = '{mode: 1'b0, nif_k_k: 32'd7,  of: 32'd40,  base_adr: 32'h0000_0300};
      3: c = '{mode: 1'b1, nif_k_k: 32'd16, of: 32'd300, base_adr: 32'h0000_8000};
      default: c = '0;
    endcase
    return c;
  endfunction

  function automatic int tile_count(input layer_cfg_t c);
    int rn;
    rn = c.mode ? row_num_mode1 : row_num_mode0;
    return (int'(c.of) + rn - 1) / rn;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog, sized from the layer table
  initial begin
    layer_cfg_t c;
    int limit;
    limit = 40;
    for (int i = 0; i < num_tests; i++) begin
      c = test_cfg(i);
      limit += tile_count(c) * (int'(c.nif_k_k) * 8 + 20);
    end
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////
  // tasks
  ////////////////////////////////////////

  task automatic wait_tile_ready();
    do begin
      @(posedge clk);
      #2;
    end while (!tile_ready);
  endtask

  task automatic read_tile(input logic [cnt_w-1:0] words);
    for (int unsigned i = 0; i < words; i++) begin
      buf_rd_en  = 1'b1;
      buf_rd_adr = buf_adr_w'(i);
      @(posedge clk);
      #2;
    end
    buf_rd_en = 1'b0;
  endtask

  task automatic run_layer(input int idx);
    layer_cfg_t  c;
    int unsigned fails_before;
    int          tiles;
    logic        done;
    c            = test_cfg(idx);
    fails_before = dut.u_sva.fail_cnt;
    tiles        = 0;
    done         = 1'b0;
    @(posedge clk);
    #2;
    layer_start = 1'b1;
    layer_cfg   = c;
    @(posedge clk);
    #2;
    layer_start = 1'b0;
    // read each tile back, then hand it over
    while (!done) begin
      wait_tile_ready();
      tiles++;
      read_tile(c.nif_k_k);
      tile_consumed = 1'b1;
      @(posedge clk);
      #2;
      tile_consumed = 1'b0;
      done = layer_done;
    end
    if (dut.u_sva.fail_cnt == fails_before) begin
      tests_passed++;
      $display("layer %0d mode %0d of %0d nif_k_k %0d: %0d tiles, ok",
               idx, c.mode, c.of, c.nif_k_k, tiles);
    end else begin
      tests_failed++;
      $display("layer %0d mode %0d of %0d nif_k_k %0d: %0d tiles, %0d failed checks",
               idx, c.mode, c.of, c.nif_k_k, tiles, dut.u_sva.fail_cnt - fails_before);
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h6e53_7ec2));
    reset         = 1'b1;
    layer_start   = 1'b0;
    layer_cfg     = '0;
    tile_consumed = 1'b0;
    buf_rd_en     = 1'b0;
    buf_rd_adr    = '0;
    tests_passed  = 0;
    tests_failed  = 0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    // idle a little so the quiet outputs get seen
    repeat (4) @(posedge clk);
    for (int i = 0; i < num_tests; i++) begin
      run_layer(i);
    end
    $display("tests: %0d passed, %0d failed, %0d assertion failures",
             tests_passed, tests_failed, dut.u_sva.fail_cnt);
    if (tests_failed == 0 && dut.u_sva.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tests/ddr_read_model.sv
`timescale 1ns/100ps

module ddr_read_model
  import conv_weights_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  ddr_rd_req_t ddr_rd_req,
  output logic        ddr_en,
  output ddr_rd_rsp_t ddr_rd_rsp
);

  // outstanding reads, oldest first
  logic [ddr_adr_w-1:0] adr_q [$];
  int unsigned          due_q [$];
  int unsigned          cyc;
  int unsigned          last_due;
  int unsigned          due;

  initial begin
    ddr_en     = 1'b0;
    ddr_rd_rsp = '0;
    cyc        = 0;
    last_due   = 0;
    forever begin
      // request is settled by mid-cycle
      @(negedge clk);
      if (reset) begin
        adr_q.delete();
        due_q.delete();
      end else if (ddr_rd_req.en) begin
        due = cyc + 1 + $urandom_range(3);
        // in order, at most one word per cycle
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        adr_q.push_back(ddr_rd_req.adr);
        due_q.push_back(due);
      end
      @(posedge clk);
      #2;
      cyc++;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        ddr_rd_rsp.valid = 1'b1;
        ddr_rd_rsp.data  = adr_q.pop_front() ^ 32'hA5A5_0000;
        void'(due_q.pop_front());
      end else begin
        ddr_rd_rsp = '0;
      end
      // stall about one cycle in four
      ddr_en = ($urandom_range(3) != 0);
    end
  end

endmodule

// File: tests/conv_weights_sva.sv
`timescale 1ns/100ps

module conv_weights_sva
  import conv_weights_pkg::*;
#(
  parameter int row_num_mode0 = 64,
  parameter int row_num_mode1 = 128,
  parameter int buf_adr_w     = 10
) (
  input logic                 clk,
  input logic                 reset,
  input logic                 layer_start,
  input layer_cfg_t           layer_cfg,
  input logic                 ddr_en,
  input ddr_rd_req_t          ddr_rd_req,
  input logic                 tile_ready,
  input logic                 tile_consumed,
  input logic                 buf_rd_en,
  input logic [buf_adr_w-1:0] buf_rd_adr,
  input weights_word_t        buf_rd_data,
  input logic                 layer_done
);

  int unsigned          fail_cnt = 0;
  layer_cfg_t           cfg;
  logic                 started;
  logic                 ready_q;
  logic                 ready_rise;
  logic [cnt_w-1:0]     row_num;
  logic [cnt_w-1:0]     exp_tiles;
  logic [cnt_w-1:0]     ready_cnt;
  logic [cnt_w-1:0]     tile_idx;
  logic [cnt_w-1:0]     tile_req;
  logic [ddr_adr_w-1:0] exp_adr;
  weights_word_t        rd_exp;

  assign row_num    = cfg.mode ? cnt_w'(row_num_mode1) : cnt_w'(row_num_mode0);
  assign exp_tiles  = (cfg.of + row_num - 1) / row_num;
  assign ready_rise = tile_ready && !ready_q;
  assign exp_adr    = cfg.base_adr + tile_idx * cfg.nif_k_k + tile_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= tile_ready;
      if (layer_start) begin
        started <= 1'b1;
      end
    end
  end

  // reference position of the loader within the layer
  always_ff @(posedge clk) begin
    if (layer_start) begin
      cfg       <= layer_cfg;
      ready_cnt <= '0;
      tile_idx  <= '0;
      tile_req  <= '0;
    end else begin
      if (ready_rise) begin
        ready_cnt <= ready_cnt + 1'b1;
      end
      if (tile_ready && tile_consumed) begin
        tile_idx <= tile_idx + 1'b1;
        tile_req <= '0;
      end else if (ddr_rd_req.en) begin
        tile_req <= tile_req + 1'b1;
      end
    end
  end

  // word read back from the buffer
  always_ff @(posedge clk) begin
    if (buf_rd_en) begin
      rd_exp <= (cfg.base_adr + tile_idx * cfg.nif_k_k + cnt_w'(buf_rd_adr)) ^ 32'hA5A5_0000;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
    !started |-> !ddr_rd_req.en && !tile_ready && !layer_done)
  else begin
    $error("DRAM request, tile_ready or layer_done active before the first layer_start");
    fail_cnt++;
  end

  a_backpressure: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_req.en |-> ddr_en)
  else begin
    $error("DRAM request issued while ddr_en was low");
    fail_cnt++;
  end

  a_req_adr: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_req.en |-> ddr_rd_req.adr == exp_adr)
  else begin
    $error("mismatch at %0t: ddr_rd_req.adr expected %h got %h",
           $time, $sampled(exp_adr), $sampled(ddr_rd_req.adr));
    fail_cnt++;
  end

  a_req_count: assert property (@(posedge clk) disable iff (reset)
    ready_rise |-> tile_req == cfg.nif_k_k)
  else begin
    $error("mismatch at %0t: requests per tile expected %0d got %0d",
           $time, $sampled(cfg.nif_k_k), $sampled(tile_req));
    fail_cnt++;
  end

  a_rd_data: assert property (@(posedge clk) disable iff (reset)
    buf_rd_en |=> buf_rd_data == rd_exp)
  else begin
    $error("mismatch at %0t: buf_rd_data expected %h got %h",
           $time, $sampled(rd_exp), $sampled(buf_rd_data));
    fail_cnt++;
  end

  a_tile_count: assert property (@(posedge clk) disable iff (reset)
    layer_done |-> ready_cnt == exp_tiles)
  else begin
    $error("mismatch at %0t: tile count expected %0d got %0d",
           $time, $sampled(exp_tiles), $sampled(ready_cnt));
    fail_cnt++;
  end

  // one cycle after the last tile is consumed, and only then
  a_done_timing: assert property (@(posedge clk) disable iff (reset)
    layer_done |-> $past(tile_ready && tile_consumed) && !tile_ready)
  else begin
    $error("layer_done not in the cycle right after tile_consumed, or seen with tile_ready");
    fail_cnt++;
  end

  a_done_follows: assert property (@(posedge clk) disable iff (reset)
    tile_ready && tile_consumed && ready_cnt == exp_tiles |=> layer_done)
  else begin
    $error("layer_done missing after the last tile was consumed");
    fail_cnt++;
  end

endmodule

// File: hw/conv_weights_top.sv
`timescale 1ns/100ps

module conv_weights_top
  import conv_weights_pkg::*;
#(
  parameter int row_num_mode0 = 64,
  parameter int row_num_mode1 = 128,
  parameter int buf_adr_w     = 10
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 layer_start,
  input  layer_cfg_t           layer_cfg,
  input  logic                 ddr_en,
  output ddr_rd_req_t          ddr_rd_req,
  input  ddr_rd_rsp_t          ddr_rd_rsp,
  output logic                 tile_ready,
  input  logic                 tile_consumed,
  input  logic                 buf_rd_en,
  input  logic [buf_adr_w-1:0] buf_rd_adr,
  output weights_word_t        buf_rd_data,
  output logic                 layer_done
);

  logic                 load_tile;
  logic                 tile_fin;
  logic                 last_tile;
  logic                 buf_wr_en;
  logic [buf_adr_w-1:0] buf_wr_adr;
  weights_word_t        buf_wr_data;

  ////////////////////////////////////////
  // tile control
  ////////////////////////////////////////

  conv_tile_sequencer u_seq (
    .clk           (clk),
    .reset         (reset),
    .layer_start   (layer_start),
    .tile_fin      (tile_fin),
    .last_tile     (last_tile),
    .tile_consumed (tile_consumed),
    .load_tile     (load_tile),
    .tile_ready    (tile_ready),
    .layer_done    (layer_done)
  );

  ////////////////////////////////////////
  // DRAM to buffer
  ////////////////////////////////////////

  conv_load_weights_controller #(
    .row_num_mode0 (row_num_mode0),
    .row_num_mode1 (row_num_mode1),
    .buf_adr_w     (buf_adr_w)
  ) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .layer_start (layer_start),
    .layer_cfg   (layer_cfg),
    .load_tile   (load_tile),
    .ddr_en      (ddr_en),
    .ddr_rd_rsp  (ddr_rd_rsp),
    .ddr_rd_req  (ddr_rd_req),
    .buf_wr_en   (buf_wr_en),
    .buf_wr_adr  (buf_wr_adr),
    .buf_wr_data (buf_wr_data),
    .tile_fin    (tile_fin),
    .last_tile   (last_tile)
  );

  weights_buf #(
    .buf_adr_w (buf_adr_w)
  ) u_buf (
    .clk     (clk),
    .wr_en   (buf_wr_en),
    .wr_adr  (buf_wr_adr),
    .wr_data (buf_wr_data),
    .rd_en   (buf_rd_en),
    .rd_adr  (buf_rd_adr),
    .rd_data (buf_rd_data)
  );

endmodule

// File: hw/conv_tile_sequencer.sv
`timescale 1ns/100ps

module conv_tile_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic layer_start,
  input  logic tile_fin,
  input  logic last_tile,
  input  logic tile_consumed,
  output logic load_tile,
  output logic tile_ready,
  output logic layer_done
);

  typedef enum logic [1:0] {
    idle,
    loading,
    ready,
    drain
  } state_t;

  state_t state;
  logic   last_q;
  logic   next_tile;

  // consumed tile was not the last one
  assign next_tile = (state == ready) && tile_consumed && !last_q;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (layer_start) state <= loading;
        loading: if (tile_fin) state <= ready;
        ready: begin
          if (tile_consumed) begin
            state <= last_q ? drain : loading;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // remember the last flag until compute lets go of the tile
  always_ff @(posedge clk) begin
    if (reset) begin
      last_q <= 1'b0;
    end else if (tile_fin) begin
      last_q <= last_tile;
    end
  end

  // one-cycle start, after layer_start or after a consumed tile
  always_ff @(posedge clk) begin
    if (reset) begin
      load_tile <= 1'b0;
    end else begin
      load_tile <= ((state == idle) && layer_start) || next_tile;
    end
  end

  assign tile_ready = (state == ready);
  assign layer_done = (state == drain);

endmodule

// File: load_weights/weights_buf.sv
`timescale 1ns/100ps

module weights_buf
  import conv_weights_pkg::*;
#(
  parameter int buf_adr_w = 10
) (
  input  logic                 clk,
  input  logic                 wr_en,
  input  logic [buf_adr_w-1:0] wr_adr,
  input  weights_word_t        wr_data,
  input  logic                 rd_en,
  input  logic [buf_adr_w-1:0] rd_adr,
  output weights_word_t        rd_data
);

  localparam int depth = 2 ** buf_adr_w;

  // one tile of weights, nif_k_k words deep at most
  weights_word_t mem [depth];

  ////////////////////////////////////////
  // write port, loader side
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_adr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // read port, compute side
  ////////////////////////////////////////

  // data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_adr];
    end
  end

endmodule

// File: load_weights/conv_load_weights_controller.sv
`timescale 1ns/100ps

module conv_load_weights_controller
  import conv_weights_pkg::*;
#(
  parameter int row_num_mode0 = 64,
  parameter int row_num_mode1 = 128,
  parameter int buf_adr_w     = 10
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 layer_start,
  input  layer_cfg_t           layer_cfg,
  input  logic                 load_tile,
  input  logic                 ddr_en,
  input  ddr_rd_rsp_t          ddr_rd_rsp,
  output ddr_rd_req_t          ddr_rd_req,
  output logic                 buf_wr_en,
  output logic [buf_adr_w-1:0] buf_wr_adr,
  output weights_word_t        buf_wr_data,
  output logic                 tile_fin,
  output logic                 last_tile
);

  layer_cfg_t           cfg;
  logic [cnt_w-1:0]     row_num;
  logic [cnt_w-1:0]     words_last;

  // request side
  logic                 req_active;
  logic [cnt_w-1:0]     req_cnt;
  logic                 req_fire;
  logic                 req_last;

  // tile position in the layer
  logic [cnt_w-1:0]     tile_start_ch;
  logic [ddr_adr_w-1:0] tile_base;
  logic                 tile_is_last;
  logic                 last_q;

  // return side
  logic [buf_adr_w-1:0] wr_cnt;
  logic                 wr_last;
  logic                 req_done;

  ////////////////////////////////////////
  // layer config
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (layer_start) begin
      cfg <= layer_cfg;
    end
  end

  assign row_num    = cfg.mode ? cnt_w'(row_num_mode1) : cnt_w'(row_num_mode0);
  assign words_last = cfg.nif_k_k - 1'b1;

  ////////////////////////////////////////
  // DRAM requests
  ////////////////////////////////////////

  // issuing from load_tile until the last word of the tile goes out
  always_ff @(posedge clk) begin
    if (reset) begin
      req_active <= 1'b0;
    end else if (load_tile) begin
      req_active <= 1'b1;
    end else if (req_last) begin
      req_active <= 1'b0;
    end
  end

  assign req_fire = req_active && ddr_en;
  assign req_last = req_fire && (req_cnt == words_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      req_cnt <= '0;
    end else if (req_fire) begin
      if (req_last) begin
        req_cnt <= '0;
      end else begin
        req_cnt <= req_cnt + 1'b1;
      end
    end
  end

  // address holds while ddr_en is low
  assign ddr_rd_req.en  = req_fire;
  assign ddr_rd_req.adr = cfg.base_adr + tile_base + req_cnt;

  ////////////////////////////////////////
  // tile walk over output channels
  ////////////////////////////////////////

  // tile reaches the last output channel
  assign tile_is_last = (tile_start_ch + row_num) >= cfg.of;

  // steps one tile per finished request run, wraps at layer end
  always_ff @(posedge clk) begin
    if (reset || layer_start) begin
      tile_start_ch <= '0;
      tile_base     <= '0;
    end else if (req_last) begin
      if (tile_is_last) begin
        tile_start_ch <= '0;
        tile_base     <= '0;
      end else begin
        tile_start_ch <= tile_start_ch + row_num;
        tile_base     <= tile_base + cfg.nif_k_k;
      end
    end
  end

  // counters have moved on by the time the data is in
  always_ff @(posedge clk) begin
    if (reset) begin
      last_q <= 1'b0;
    end else if (req_last) begin
      last_q <= tile_is_last;
    end
  end

  ////////////////////////////////////////
  // buffer writes
  ////////////////////////////////////////

  assign wr_last = ddr_rd_rsp.valid && (cnt_w'(wr_cnt) == words_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_cnt <= '0;
    end else if (ddr_rd_rsp.valid) begin
      if (wr_last) begin
        wr_cnt <= '0;
      end else begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  assign buf_wr_en   = ddr_rd_rsp.valid;
  assign buf_wr_adr  = wr_cnt;
  assign buf_wr_data = ddr_rd_rsp.data;

  // all requests out, now wait for the last word back
  always_ff @(posedge clk) begin
    if (reset) begin
      req_done <= 1'b0;
    end else if (req_last) begin
      req_done <= 1'b1;
    end else if (tile_fin) begin
      req_done <= 1'b0;
    end
  end

  assign tile_fin  = req_done && wr_last;
  assign last_tile = last_q;

endmodule

// File: common/conv_weights_pkg.sv
package conv_weights_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int word_w    = 32;
  localparam int ddr_adr_w = 32;
  localparam int cnt_w     = 32;

  // one weight word as stored in DRAM and in the buffer
  typedef logic [word_w-1:0] weights_word_t;

  ////////////////////////////////////////
  // layer configuration
  ////////////////////////////////////////

  // mode 0 or 1 picks the output-channel tile width
  typedef struct packed {
    logic                 mode;
    logic [cnt_w-1:0]     nif_k_k;
    logic [cnt_w-1:0]     of;
    logic [ddr_adr_w-1:0] base_adr;
  } layer_cfg_t;

  ////////////////////////////////////////
  // DRAM read port
  ////////////////////////////////////////

  // request, one word address per cycle
  typedef struct packed {
    logic                 en;
    logic [ddr_adr_w-1:0] adr;
  } ddr_rd_req_t;

  // returned word, in request order
  typedef struct packed {
    logic          valid;
    weights_word_t data;
  } ddr_rd_rsp_t;

endpackage
